// File: include/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// write and read port widths in bits
`define FIFO_W_DATA_W 8
`define FIFO_R_DATA_W 32

// depth as log2 of the number of narrow words
`define FIFO_ADDR_W 6

// wide and narrow side, and how many narrow words fit in one row
`define FIFO_MAX_W ((`FIFO_W_DATA_W > `FIFO_R_DATA_W) ? `FIFO_W_DATA_W : `FIFO_R_DATA_W)
`define FIFO_MIN_W ((`FIFO_W_DATA_W > `FIFO_R_DATA_W) ? `FIFO_R_DATA_W : `FIFO_W_DATA_W)
`define FIFO_RATIO (`FIFO_MAX_W / `FIFO_MIN_W)

// ram row address, and the address width seen by each port
`define FIFO_MEM_ADDR_W (`FIFO_ADDR_W - $clog2(`FIFO_RATIO))
`define FIFO_W_ADDR_W ((`FIFO_W_DATA_W == `FIFO_MAX_W) ? `FIFO_MEM_ADDR_W : `FIFO_ADDR_W)
`define FIFO_R_ADDR_W ((`FIFO_R_DATA_W == `FIFO_MAX_W) ? `FIFO_MEM_ADDR_W : `FIFO_ADDR_W)

`endif

// File: src/fifo_pkg.sv
package fifo_pkg;

`include "fifo_params.svh"

   // one word on the write port
   typedef logic [`FIFO_W_DATA_W-1:0] w_data_t;

   // one word on the read port
   typedef logic [`FIFO_R_DATA_W-1:0] r_data_t;

   // full ram row, always as wide as the wider port
   typedef logic [`FIFO_MAX_W-1:0] mem_word_t;

   // one enable bit per narrow lane of a row
   typedef logic [`FIFO_RATIO-1:0] lane_en_t;

   // row address into the ram
   typedef logic [`FIFO_MEM_ADDR_W-1:0] mem_addr_t;

   // fill level in narrow words, one extra bit so a full fifo fits
   typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

// File: src/fifo_mem_if.sv
`timescale 1ns/1ps

interface fifo_mem_if;

   // write port, one enable per lane
   fifo_pkg::lane_en_t  w_lane_en;
   fifo_pkg::mem_addr_t w_addr;
   fifo_pkg::mem_word_t w_data;

   // read port, data comes back one cycle after r_en
   logic                r_en;
   fifo_pkg::mem_addr_t r_addr;
   fifo_pkg::mem_word_t r_data;

   modport ctrl (
      output w_lane_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   modport mem (
      input  w_lane_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

// File: src/fifo_asym_converter.sv
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_asym_converter (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   input  logic                             w_en_i,
   input  logic [`FIFO_W_ADDR_W-1:0]        w_addr_i,
   input  fifo_pkg::w_data_t                w_data_i,
   input  logic                             r_en_i,
   input  logic [`FIFO_R_ADDR_W-1:0]        r_addr_i,
   output fifo_pkg::r_data_t                r_data_o,
   fifo_mem_if.ctrl                         mem
);

   localparam int W_W     = `FIFO_W_DATA_W;
   localparam int R_W     = `FIFO_R_DATA_W;
   localparam int RATIO   = `FIFO_RATIO;
   localparam int MEM_A_W = `FIFO_MEM_ADDR_W;
   localparam int W_A_W   = `FIFO_W_ADDR_W;
   localparam int R_A_W   = `FIFO_R_ADDR_W;

   generate
      if (W_W > R_W) begin : g_write_wider
         localparam int LANE_W = $clog2(RATIO);

         logic [LANE_W-1:0] r_lane_q;

         // a whole row per write
         assign mem.w_addr    = w_addr_i;
         assign mem.w_lane_en = {RATIO{w_en_i}};
         assign mem.w_data    = w_data_i;

         // upper bits pick the row, low bits pick the lane
         assign mem.r_en   = r_en_i;
         assign mem.r_addr = r_addr_i[R_A_W-1 -: MEM_A_W];

         // lane select follows the registered ram read by one cycle
         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               r_lane_q <= '0;
            end else if (r_en_i) begin
               r_lane_q <= r_addr_i[LANE_W-1:0];
            end
         end

         // lane 0 is the oldest word, little endian
         assign r_data_o = mem.r_data[r_lane_q*R_W +: R_W];

      end else if (R_W > W_W) begin : g_read_wider
         localparam int LANE_W = $clog2(RATIO);

         logic [LANE_W-1:0] w_lane;

         assign w_lane = w_addr_i[LANE_W-1:0];

         // row from the upper address bits
         assign mem.w_addr = w_addr_i[W_A_W-1 -: MEM_A_W];

         // one hot lane, so only the addressed byte lands
         assign mem.w_lane_en = w_en_i ? (fifo_pkg::lane_en_t'(1) << w_lane) : '0;

         // same word on every lane, the enable decides
         assign mem.w_data = {RATIO{w_data_i}};

         // full rows go straight out
         assign mem.r_en   = r_en_i;
         assign mem.r_addr = r_addr_i;
         assign r_data_o   = mem.r_data;

      end else begin : g_same_width
         // no conversion needed
         assign mem.w_addr    = w_addr_i;
         assign mem.w_lane_en = {RATIO{w_en_i}};
         assign mem.w_data    = w_data_i;
         assign mem.r_en      = r_en_i;
         assign mem.r_addr    = r_addr_i;
         assign r_data_o      = mem.r_data;
      end
   endgenerate

endmodule

// File: src/fifo_ram_2p.sv
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_ram_2p (
   input logic     clk_i,
   fifo_mem_if.mem mem
);

   localparam int DEPTH  = 1 << `FIFO_MEM_ADDR_W;
   localparam int RATIO  = `FIFO_RATIO;
   localparam int LANE_W = `FIFO_MIN_W;

   fifo_pkg::mem_word_t ram_q [DEPTH];
   fifo_pkg::mem_word_t r_data_q;

   // byte lane writes, each under its own enable
   always_ff @(posedge clk_i) begin
      for (int lane = 0; lane < RATIO; lane++) begin
         if (mem.w_lane_en[lane]) begin
            ram_q[mem.w_addr][lane*LANE_W +: LANE_W] <= mem.w_data[lane*LANE_W +: LANE_W];
         end
      end
   end

   // registered read, holds the last row until the next read
   always_ff @(posedge clk_i) begin
      if (mem.r_en) begin
         r_data_q <= ram_q[mem.r_addr];
      end
   end

   assign mem.r_data = r_data_q;

   // lane enables come from the fifo controller and must be clean
   // or a random lane gets corrupted
   a_lane_en_known : assert property (
      @(posedge clk_i) !$isunknown(mem.w_lane_en)
   ) else $error("fifo_ram_2p: w_lane_en unknown");

endmodule

// File: src/fifo_sync_asym.sv
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_sync_asym (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              clr_i,
   input  logic              w_en_i,
   input  fifo_pkg::w_data_t w_data_i,
   output logic              w_full_o,
   input  logic              r_en_i,
   output fifo_pkg::r_data_t r_data_o,
   output logic              r_empty_o,
   output fifo_pkg::level_t  level_o,
   fifo_mem_if.ctrl          mem
);

   localparam int W_A_W = `FIFO_W_ADDR_W;
   localparam int R_A_W = `FIFO_R_ADDR_W;

   // level steps in narrow words per accepted operation
   localparam fifo_pkg::level_t W_INCR =
      (`FIFO_W_DATA_W > `FIFO_R_DATA_W) ? fifo_pkg::level_t'(`FIFO_RATIO) : fifo_pkg::level_t'(1);
   localparam fifo_pkg::level_t R_INCR =
      (`FIFO_R_DATA_W > `FIFO_W_DATA_W) ? fifo_pkg::level_t'(`FIFO_RATIO) : fifo_pkg::level_t'(1);

   // capacity in narrow words
   localparam fifo_pkg::level_t DEPTH = fifo_pkg::level_t'(1 << `FIFO_ADDR_W);

   logic             w_en_int;
   logic             r_en_int;
   logic [W_A_W-1:0] w_addr_q;
   logic [W_A_W-1:0] w_addr_nxt;
   logic [R_A_W-1:0] r_addr_q;
   logic [R_A_W-1:0] r_addr_nxt;
   fifo_pkg::level_t level_q;
   fifo_pkg::level_t level_nxt;
   logic             r_empty_q;
   logic             w_full_q;

   // accepted operations, clear wins over both
   assign w_en_int = w_en_i & ~w_full_q & ~clr_i;
   assign r_en_int = r_en_i & ~r_empty_q & ~clr_i;

   // next addresses and level
   always_comb begin
      w_addr_nxt = w_addr_q;
      r_addr_nxt = r_addr_q;
      level_nxt  = level_q;
      if (clr_i) begin
         w_addr_nxt = '0;
         r_addr_nxt = '0;
         level_nxt  = '0;
      end else begin
         if (w_en_int) begin
            // wraps at the end of the buffer
            w_addr_nxt = w_addr_q + W_A_W'(1);
            level_nxt  = level_nxt + W_INCR;
         end
         if (r_en_int) begin
            r_addr_nxt = r_addr_q + R_A_W'(1);
            level_nxt  = level_nxt - R_INCR;
         end
      end
   end

   // flags come from the next level so they move with level_o
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         w_addr_q  <= '0;
         r_addr_q  <= '0;
         level_q   <= '0;
         r_empty_q <= 1'b1;
         w_full_q  <= 1'b0;
      end else begin
         w_addr_q  <= w_addr_nxt;
         r_addr_q  <= r_addr_nxt;
         level_q   <= level_nxt;
         r_empty_q <= (level_nxt < R_INCR);
         w_full_q  <= (level_nxt > (DEPTH - W_INCR));
      end
   end

   assign level_o   = level_q;
   assign r_empty_o = r_empty_q;
   assign w_full_o  = w_full_q;

   // address and data mapping onto the ram rows
   fifo_asym_converter fifo_asym_converter_inst (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .w_en_i   (w_en_int),
      .w_addr_i (w_addr_q),
      .w_data_i (w_data_i),
      .r_en_i   (r_en_int),
      .r_addr_i (r_addr_q),
      .r_data_o (r_data_o),
      .mem      (mem)
   );

   // the level can never pass the capacity
   a_level_bound : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      level_q <= DEPTH
   ) else $error("fifo_sync_asym: level 0x%0h above depth", level_q);

   // empty and full are exclusive
   a_flags_excl : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !(r_empty_q && w_full_q)
   ) else $error("fifo_sync_asym: empty and full both set");

endmodule

// File: src/fifo_subsys_top.sv
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_subsys_top (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      clr_i,

   // write side
   input  logic                      w_en_i,
   input  logic [`FIFO_W_DATA_W-1:0] w_data_i,
   output logic                      w_full_o,

   // read side
   input  logic                      r_en_i,
   output logic [`FIFO_R_DATA_W-1:0] r_data_o,
   output logic                      r_empty_o,

   // fill level in bytes
   output logic [`FIFO_ADDR_W:0]     level_o
);

   // ram write and read ports
   fifo_mem_if mem_if ();

   fifo_sync_asym fifo_sync_asym_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .clr_i     (clr_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o),
      .mem       (mem_if.ctrl)
   );

   fifo_ram_2p fifo_ram_2p_inst (
      .clk_i (clk_i),
      .mem   (mem_if.mem)
   );

endmodule

// File: testbench/tb_fifo_subsys.sv
`timescale 1ns/1ps
`include "fifo_params.svh"

module tb_fifo_subsys;

   localparam int TIMEOUT_CYCLES = 100;
   localparam int DEPTH          = 1 << `FIFO_ADDR_W;
   localparam int WORD_BYTES     = `FIFO_R_DATA_W / `FIFO_W_DATA_W;

   logic                      clk_i;
   logic                      rst_n_i;
   logic                      clr_i;
   logic                      w_en_i;
   logic [`FIFO_W_DATA_W-1:0] w_data_i;
   logic                      w_full_o;
   logic                      r_en_i;
   logic [`FIFO_R_DATA_W-1:0] r_data_o;
   logic                      r_empty_o;
   logic [`FIFO_ADDR_W:0]     level_o;

   // bytes in write order with the oldest at the front
   logic [7:0] model_q [$];
   int         errors;
   int         checks;

   fifo_subsys_top fifo_subsys_top_inst (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .clr_i     (clr_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .w_full_o  (w_full_o),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   function automatic logic [7:0] random_byte();
      logic [31:0] rnd;
      rnd = $urandom();
      return rnd[7:0];
   endfunction

   // first byte written ends up in bits 7:0
   function automatic logic [31:0] pop_word();
      logic [31:0] word;
      word = '0;
      for (int i = 0; i < WORD_BYTES; i++) begin
         if (model_q.size() > 0) begin
            word[i*8 +: 8] = model_q.pop_front();
         end
      end
      return word;
   endfunction

   // all waits start and end 1 ns after a rising edge
   task automatic wait_not_full();
      int cycles;
      cycles = 0;
      while (w_full_o && cycles < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      assert (!w_full_o) else begin
         errors++;
         $display("timeout: w_full_o stayed high, write never accepted");
      end
   endtask

   task automatic wait_not_empty();
      int cycles;
      cycles = 0;
      while (r_empty_o && cycles < TIMEOUT_CYCLES) begin
         @(posedge clk_i);
         #1;
         cycles++;
      end
      assert (!r_empty_o) else begin
         errors++;
         $display("timeout: r_empty_o stayed high, read never accepted");
      end
   endtask

   task automatic write_byte(input logic [7:0] b);
      wait_not_full();
      w_en_i   = 1'b1;
      w_data_i = b;
      @(posedge clk_i);
      #1;
      w_en_i = 1'b0;
      model_q.push_back(b);
   endtask

   task automatic read_and_check();
      logic [31:0] exp;
      wait_not_empty();
      r_en_i = 1'b1;
      @(posedge clk_i);
      #1;
      r_en_i = 1'b0;
      exp = pop_word();
      check_value("r_data_o", r_data_o, exp);
   endtask

   task automatic reset_state_test();
      $display("test: reset state");
      check_value("r_empty_o", 32'(r_empty_o), 1);
      check_value("w_full_o", 32'(w_full_o), 0);
      check_value("level_o", 32'(level_o), 0);
   endtask

   task automatic packing_test();
      $display("test: packing");
      for (int i = 0; i < WORD_BYTES; i++) begin
         write_byte(random_byte());
         check_value("level_o", 32'(level_o), i + 1);
         check_value("r_empty_o", 32'(r_empty_o), 32'(i < WORD_BYTES - 1));
      end
      read_and_check();
      check_value("level_o", 32'(level_o), 0);
      check_value("r_empty_o", 32'(r_empty_o), 1);
   endtask

   task automatic full_test();
      $display("test: full");
      for (int i = 0; i < DEPTH; i++) begin
         write_byte(random_byte());
         check_value("level_o", 32'(level_o), i + 1);
         check_value("w_full_o", 32'(w_full_o), 32'(i == DEPTH - 1));
      end
      // the FIFO drops this byte so the model never sees it
      w_en_i   = 1'b1;
      w_data_i = random_byte();
      @(posedge clk_i);
      #1;
      w_en_i = 1'b0;
      check_value("level_o", 32'(level_o), DEPTH);
      check_value("w_full_o", 32'(w_full_o), 1);
   endtask

   task automatic drain_test();
      logic [31:0] exp;
      logic [31:0] last_word;
      $display("test: drain");
      last_word = '0;
      wait_not_empty();
      r_en_i = 1'b1;
      for (int k = 0; k < DEPTH / WORD_BYTES; k++) begin
         @(posedge clk_i);
         #1;
         exp = pop_word();
         check_value("r_data_o", r_data_o, exp);
         check_value("level_o", 32'(level_o), DEPTH - WORD_BYTES * (k + 1));
         last_word = exp;
      end
      r_en_i = 1'b0;
      check_value("r_empty_o", 32'(r_empty_o), 1);
      // a read while empty must leave everything as it was
      r_en_i = 1'b1;
      @(posedge clk_i);
      #1;
      r_en_i = 1'b0;
      check_value("level_o", 32'(level_o), 0);
      check_value("r_empty_o", 32'(r_empty_o), 1);
      check_value("r_data_o", r_data_o, last_word);
   endtask

   task automatic simultaneous_test();
      logic [7:0]  b;
      logic [31:0] exp;
      $display("test: simultaneous write and read");
      for (int i = 0; i < 2 * WORD_BYTES; i++) begin
         write_byte(random_byte());
      end
      check_value("level_o", 32'(level_o), 2 * WORD_BYTES);
      wait_not_full();
      wait_not_empty();
      b        = random_byte();
      w_en_i   = 1'b1;
      w_data_i = b;
      r_en_i   = 1'b1;
      @(posedge clk_i);
      #1;
      w_en_i = 1'b0;
      r_en_i = 1'b0;
      exp = pop_word();
      model_q.push_back(b);
      check_value("r_data_o", r_data_o, exp);
      check_value("level_o", 32'(level_o), 2 * WORD_BYTES + 1 - WORD_BYTES);
      // top up to whole words and read back in order
      for (int i = 0; i < WORD_BYTES - 1; i++) begin
         write_byte(random_byte());
      end
      read_and_check();
      read_and_check();
      check_value("level_o", 32'(level_o), 0);
   endtask

   task automatic clear_test();
      $display("test: clear");
      for (int i = 0; i < 6; i++) begin
         write_byte(random_byte());
      end
      clr_i = 1'b1;
      @(posedge clk_i);
      #1;
      clr_i = 1'b0;
      model_q.delete();
      check_value("level_o", 32'(level_o), 0);
      check_value("r_empty_o", 32'(r_empty_o), 1);
      check_value("w_full_o", 32'(w_full_o), 0);
      for (int i = 0; i < 2 * WORD_BYTES; i++) begin
         write_byte(random_byte());
      end
      read_and_check();
      read_and_check();
      check_value("level_o", 32'(level_o), 0);
   endtask

   initial begin
      rst_n_i  = 1'b0;
      clr_i    = 1'b0;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      errors   = 0;
      checks   = 0;
      void'($urandom(32'h8b85af46));
      repeat (16) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      @(posedge clk_i);
      #1;
      reset_state_test();
      packing_test();
      full_test();
      drain_test();
      simultaneous_test();
      clear_test();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: sim.f
+incdir+include
src/fifo_pkg.sv
src/fifo_mem_if.sv
src/fifo_asym_converter.sv
src/fifo_ram_2p.sv
src/fifo_sync_asym.sv
src/fifo_subsys_top.sv
testbench/tb_fifo_subsys.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_fifo_subsys
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
